//--- hdl/vtp_pkg.sv
package vtp_pkg;

    // ======================================================================
    // Address widths
    // ======================================================================

    // Client addresses are line addresses, so the page offset counts lines
    localparam int LINE_VA_BITS     = 20;
    localparam int PAGE_OFFSET_BITS = 6;
    localparam int VPAGE_BITS       = 14;
    localparam int PPAGE_BITS       = 10;
    localparam int LINE_PA_BITS     = 16;

    // ======================================================================
    // TLB geometry
    // ======================================================================

    localparam int TLB_WAYS     = 2;
    localparam int TLB_SETS     = 16;
    localparam int TLB_IDX_BITS = 4;
    // The TLB tag is the virtual page without its set index bits
    localparam int TLB_TAG_BITS = 10;

    // ======================================================================
    // Hashed page table layout in external memory
    // ======================================================================

    localparam int PT_HASH_BITS = 6;
    localparam int PT_TAG_BITS  = 8;
    // Line indices reach past the hash region into the overflow lines
    localparam int PT_IDX_BITS  = 8;
    localparam int PT_LINE_BITS = 128;
    // An 18-bit entry is stored in three whole bytes
    localparam int PTE_BITS      = 24;
    // Five entries fill bits 119 down to 0 and the next-line pointer sits in 127:120
    localparam int PTES_PER_LINE = 5;
    // The PTE countdown runs from PTES_PER_LINE down to zero
    localparam int PTE_CNT_BITS  = 3;

    typedef logic [LINE_VA_BITS-1:0]     line_va_t;
    typedef logic [LINE_PA_BITS-1:0]     line_pa_t;
    typedef logic [VPAGE_BITS-1:0]       vpage_t;
    typedef logic [PPAGE_BITS-1:0]       ppage_t;
    typedef logic [PAGE_OFFSET_BITS-1:0] page_offset_t;
    typedef logic [TLB_IDX_BITS-1:0]     tlb_idx_t;
    typedef logic [TLB_TAG_BITS-1:0]     tlb_tag_t;
    typedef logic [PT_TAG_BITS-1:0]      pt_tag_t;
    typedef logic [PT_IDX_BITS-1:0]      pt_idx_t;
    typedef logic [PT_LINE_BITS-1:0]     pt_line_t;

    // States of the page table walker
    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        READ_WAIT,
        SEARCH,
        INSERT,
        BUBBLE
    } walk_state_t;

endpackage

//--- hdl/vtp_pte_scan.sv
module vtp_pte_scan
    import vtp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     load,
    input  pt_line_t line,
    input  logic     step,
    input  logic     start,
    input  pt_tag_t  want_tag,
    output logic     match,
    output ppage_t   match_ppage,
    output logic     null_tag,
    output logic     exhausted,
    output pt_idx_t  next_idx
);

    // Line being searched where the current PTE always sits in the low bits
    pt_line_t line_q;
    // Number of PTEs not yet examined in line_q
    logic [PTE_CNT_BITS-1:0] pte_cnt;
    // Tag of the page being searched for, latched when a walk begins
    pt_tag_t search_tag;
    pt_tag_t cur_tag;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pte_cnt <= '0;
        end
        else if (load)
        begin
            pte_cnt <= PTE_CNT_BITS'(PTES_PER_LINE);
        end
        else if (step)
        begin
            pte_cnt <= pte_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            search_tag <= want_tag;
        end

        if (load)
        begin
            line_q <= line;
        end
        else if (step)
        begin
            // Entries are byte aligned so each step drops a whole PTE
            line_q <= line_q >> PTE_BITS;
        end
    end

    // A PTE holds the physical page in its low bits and the tag above it
    assign match_ppage = line_q[PPAGE_BITS-1:0];
    assign cur_tag     = line_q[PPAGE_BITS +: PT_TAG_BITS];

    // After all five shifts the next-line pointer from bits 127:120 is at the bottom
    assign exhausted = (pte_cnt == '0);
    assign next_idx  = line_q[PT_IDX_BITS-1:0];

    assign match    = !exhausted && (cur_tag == search_tag);
    assign null_tag = !exhausted && !match && (cur_tag == '0);

endmodule

//--- hdl/vtp_tlb.sv
module vtp_tlb
    import vtp_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   lookup_valid,
    input  vpage_t lookup_vpage,
    input  logic   fill_valid,
    input  vpage_t fill_vpage,
    input  ppage_t fill_ppage,
    output logic   tlb_ready,
    output logic   hit_valid,
    output ppage_t hit_ppage,
    output logic   miss_valid
);

    // ======================================================================
    // Storage
    // ======================================================================

    // A zero tag marks an empty entry
    // Valid pages never have a zero tag because the page table reserves a zero tag
    tlb_tag_t tag_mem  [TLB_WAYS][TLB_SETS];
    ppage_t   page_mem [TLB_WAYS][TLB_SETS];
    // One bit per set picks the way that the next fill replaces
    logic [TLB_SETS-1:0] victim;

    // Clearing counter where the top bit marks the end of the sweep
    logic [TLB_IDX_BITS:0] clr_cnt;
    tlb_idx_t              clr_idx;

    assign tlb_ready = clr_cnt[TLB_IDX_BITS];
    assign clr_idx   = clr_cnt[TLB_IDX_BITS-1:0];

    // Fill address split into set index and tag
    tlb_idx_t fill_idx;
    tlb_tag_t fill_tag;
    logic     fill_way;

    assign fill_idx = fill_vpage[TLB_IDX_BITS-1:0];
    assign fill_tag = fill_vpage[VPAGE_BITS-1:TLB_IDX_BITS];
    assign fill_way = victim[fill_idx];

    // ======================================================================
    // Lookup stage
    // ======================================================================

    // The page to compare is held for one cycle after the lookup strobe
    logic     look_vld;
    vpage_t   look_vpage;
    tlb_idx_t look_idx;
    tlb_tag_t look_tag;
    logic     hit_any;

    assign look_idx = look_vpage[TLB_IDX_BITS-1:0];
    assign look_tag = look_vpage[VPAGE_BITS-1:TLB_IDX_BITS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            clr_cnt  <= '0;
            look_vld <= 1'b0;
        end
        else
        begin
            // Sweep one set per cycle until every set has been cleared
            if (!tlb_ready)
            begin
                clr_cnt <= clr_cnt + 1'b1;
            end
            look_vld <= lookup_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        look_vpage <= lookup_vpage;

        if (!tlb_ready)
        begin
            for (int w = 0; w < TLB_WAYS; w++)
            begin
                tag_mem[w][clr_idx] <= '0;
            end
            victim[clr_idx] <= 1'b0;
        end
        else if (fill_valid)
        begin
            // Replace the victim way and point the set at the other way
            tag_mem[fill_way][fill_idx]  <= fill_tag;
            page_mem[fill_way][fill_idx] <= fill_ppage;
            victim[fill_idx]             <= ~victim[fill_idx];
        end
    end

    // Compare every way of the indexed set against the held tag
    always_comb
    begin
        hit_any   = 1'b0;
        hit_ppage = page_mem[0][look_idx];
        for (int w = 0; w < TLB_WAYS; w++)
        begin
            if (tag_mem[w][look_idx] == look_tag)
            begin
                hit_any   = 1'b1;
                hit_ppage = page_mem[w][look_idx];
            end
        end
    end

    // Exactly one of the two strobes follows each lookup
    assign hit_valid  = look_vld && hit_any;
    assign miss_valid = look_vld && !hit_any;

endmodule

//--- hdl/vtp_walker.sv
module vtp_walker
    import vtp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     cfg_valid,
    input  line_pa_t cfg_base,
    input  logic     miss_valid,
    input  vpage_t   miss_vpage,
    input  logic     pt_rsp_valid,
    input  pt_line_t pt_rsp_data,
    output logic     pt_rd_valid,
    output line_pa_t pt_rd_addr,
    output logic     fill_valid,
    output vpage_t   fill_vpage,
    output ppage_t   fill_ppage,
    output logic     fill_done,
    output logic     walk_error
);

    walk_state_t state;

    // Base of the page table and the line being fetched
    line_pa_t pt_base;
    pt_idx_t  line_idx;
    // Page that missed and is being searched for
    vpage_t   walk_vpage;

    // Scanner control and status
    logic    start;
    logic    load;
    logic    step;
    logic    match;
    ppage_t  match_ppage;
    logic    null_tag;
    logic    exhausted;
    pt_idx_t next_idx;
    pt_tag_t want_tag;
    pt_idx_t hash_idx;

    // Decoded search outcomes
    logic search_fail;
    logic follow_line;

    // The hash selects the first line and the remaining high bits form the tag
    assign hash_idx = pt_idx_t'(miss_vpage[PT_HASH_BITS-1:0]);
    assign want_tag = miss_vpage[VPAGE_BITS-1 -: PT_TAG_BITS];

    assign start = (state == IDLE) && miss_valid;
    assign load  = (state == READ_WAIT) && pt_rsp_valid;
    // Step past a PTE that neither matches nor ends the chain
    assign step  = (state == SEARCH) && !match && !null_tag && !exhausted;

    // A null tag or a zero next-line pointer ends the walk without a translation
    assign search_fail = (state == SEARCH) &&
                         (null_tag || (exhausted && (next_idx == '0)));
    assign follow_line = (state == SEARCH) && exhausted && (next_idx != '0);

    vtp_pte_scan pte_scan (
        .clk         (clk),
        .reset_n     (reset_n),
        .load        (load),
        .line        (pt_rsp_data),
        .step        (step),
        .start       (start),
        .want_tag    (want_tag),
        .match       (match),
        .match_ppage (match_ppage),
        .null_tag    (null_tag),
        .exhausted   (exhausted),
        .next_idx    (next_idx)
    );

    // ======================================================================
    // Walk state machine
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (miss_valid)
                    begin
                        state <= READ_REQ;
                    end
                end
                // The read strobe lasts exactly one cycle
                READ_REQ:
                begin
                    state <= READ_WAIT;
                end
                // Memory may take any number of cycles to answer
                READ_WAIT:
                begin
                    if (pt_rsp_valid)
                    begin
                        state <= SEARCH;
                    end
                end
                SEARCH:
                begin
                    if (match)
                    begin
                        state <= INSERT;
                    end
                    else if (search_fail)
                    begin
                        state <= IDLE;
                    end
                    else if (follow_line)
                    begin
                        state <= READ_REQ;
                    end
                end
                INSERT:
                begin
                    state <= BUBBLE;
                end
                // Gives the TLB write a cycle to settle before the retry
                BUBBLE:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Walk context and the base register
    always_ff @(posedge clk)
    begin
        if (cfg_valid)
        begin
            pt_base <= cfg_base;
        end

        if (start)
        begin
            walk_vpage <= miss_vpage;
            line_idx   <= hash_idx;
        end
        else if (follow_line)
        begin
            line_idx <= next_idx;
        end
    end

    assign pt_rd_valid = (state == READ_REQ);
    assign pt_rd_addr  = pt_base + line_pa_t'(line_idx);

    // The scanner holds the matched entry through INSERT since no step occurs
    assign fill_valid = (state == INSERT);
    assign fill_vpage = walk_vpage;
    assign fill_ppage = match_ppage;
    assign fill_done  = (state == BUBBLE);
    assign walk_error = search_fail;

endmodule

//--- hdl/vtp_request_path.sv
module vtp_request_path
    import vtp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     req_valid,
    input  line_va_t req_addr,
    input  logic     req_is_virtual,
    input  logic     tlb_ready,
    input  logic     hit_valid,
    input  ppage_t   hit_ppage,
    input  logic     miss_valid,
    input  logic     fill_done,
    input  logic     walk_error,
    output logic     idle,
    output logic     lookup_valid,
    output vpage_t   lookup_vpage,
    output vpage_t   miss_vpage,
    output logic     rsp_valid,
    output line_pa_t rsp_addr,
    output logic     rsp_error
);

    // One request in flight from acceptance until the cycle after its response
    logic         busy;
    // Set from a TLB miss until the walker ends with a fill or an error
    logic         walk_pend;
    // Lookup strobe for the TLB, raised for the first try and for the retry
    logic         lookup_pend;
    // Virtual address of the request in flight
    line_va_t     cur_addr;
    page_offset_t cur_offset;
    logic         accept;

    // New requests are taken only once the TLB is cleared and nothing is in flight
    assign idle   = tlb_ready && !busy;
    assign accept = req_valid && idle;

    // Split the held line address into its virtual page and line offset
    assign lookup_vpage = cur_addr[LINE_VA_BITS-1:PAGE_OFFSET_BITS];
    assign cur_offset   = cur_addr[PAGE_OFFSET_BITS-1:0];
    assign lookup_valid = lookup_pend;

    // The walker searches for the page that just missed
    assign miss_vpage = lookup_vpage;

    // ======================================================================
    // Control flags
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy        <= 1'b0;
            walk_pend   <= 1'b0;
            lookup_pend <= 1'b0;
            rsp_valid   <= 1'b0;
        end
        else
        begin
            lookup_pend <= 1'b0;
            rsp_valid   <= 1'b0;

            // The response cycle frees the path for the next request
            if (rsp_valid)
            begin
                busy <= 1'b0;
            end

            if (accept)
            begin
                busy <= 1'b1;
                // Physical requests answer in the very next cycle
                rsp_valid   <= !req_is_virtual;
                lookup_pend <= req_is_virtual;
            end

            // The walker owns the request from the miss until it reports back
            if (busy && miss_valid)
            begin
                walk_pend <= 1'b1;
            end

            // A finished fill retries the lookup, which now hits
            if (walk_pend && fill_done)
            begin
                walk_pend   <= 1'b0;
                lookup_pend <= 1'b1;
            end

            if (walk_pend && walk_error)
            begin
                walk_pend <= 1'b0;
                rsp_valid <= 1'b1;
            end

            if (busy && hit_valid)
            begin
                rsp_valid <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Request and response payload
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_addr  <= req_addr;
            rsp_addr  <= req_addr[LINE_PA_BITS-1:0];
            rsp_error <= 1'b0;
        end
        else if (hit_valid)
        begin
            // The line offset within the page is the same in both spaces
            rsp_addr  <= {hit_ppage, cur_offset};
            rsp_error <= 1'b0;
        end
        else if (walk_error)
        begin
            rsp_addr  <= '0;
            rsp_error <= 1'b1;
        end
    end

endmodule

//--- hdl/vtp_top.sv
module vtp_top
    import vtp_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,

    // Client request and response
    input  logic     req_valid,
    input  line_va_t req_addr,
    input  logic     req_is_virtual,
    output logic     idle,
    output logic     rsp_valid,
    output line_pa_t rsp_addr,
    output logic     rsp_error,

    // Page table base load
    input  logic     cfg_valid,
    input  line_pa_t cfg_base,

    // Page table line reads toward external memory
    output logic     pt_rd_valid,
    output line_pa_t pt_rd_addr,
    input  logic     pt_rsp_valid,
    input  pt_line_t pt_rsp_data
);

    // Lookup channel between the request path and the TLB
    logic   tlb_ready;
    logic   lookup_valid;
    vpage_t lookup_vpage;
    logic   hit_valid;
    ppage_t hit_ppage;
    logic   miss_valid;

    // Miss and fill channels around the walker
    vpage_t miss_vpage;
    logic   fill_valid;
    vpage_t fill_vpage;
    ppage_t fill_ppage;
    logic   fill_done;
    logic   walk_error;

    vtp_request_path request_path (
        .clk            (clk),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_is_virtual (req_is_virtual),
        .tlb_ready      (tlb_ready),
        .hit_valid      (hit_valid),
        .hit_ppage      (hit_ppage),
        .miss_valid     (miss_valid),
        .fill_done      (fill_done),
        .walk_error     (walk_error),
        .idle           (idle),
        .lookup_valid   (lookup_valid),
        .lookup_vpage   (lookup_vpage),
        .miss_vpage     (miss_vpage),
        .rsp_valid      (rsp_valid),
        .rsp_addr       (rsp_addr),
        .rsp_error      (rsp_error)
    );

    vtp_tlb tlb (
        .clk          (clk),
        .reset_n      (reset_n),
        .lookup_valid (lookup_valid),
        .lookup_vpage (lookup_vpage),
        .fill_valid   (fill_valid),
        .fill_vpage   (fill_vpage),
        .fill_ppage   (fill_ppage),
        .tlb_ready    (tlb_ready),
        .hit_valid    (hit_valid),
        .hit_ppage    (hit_ppage),
        .miss_valid   (miss_valid)
    );

    // The TLB miss strobe goes straight to the walker
    vtp_walker walker (
        .clk          (clk),
        .reset_n      (reset_n),
        .cfg_valid    (cfg_valid),
        .cfg_base     (cfg_base),
        .miss_valid   (miss_valid),
        .miss_vpage   (miss_vpage),
        .pt_rsp_valid (pt_rsp_valid),
        .pt_rsp_data  (pt_rsp_data),
        .pt_rd_valid  (pt_rd_valid),
        .pt_rd_addr   (pt_rd_addr),
        .fill_valid   (fill_valid),
        .fill_vpage   (fill_vpage),
        .fill_ppage   (fill_ppage),
        .fill_done    (fill_done),
        .walk_error   (walk_error)
    );

endmodule

//--- test/vtp_props.sv
module vtp_props
(
    input logic clk,
    input logic reset_n,
    input logic req_valid,
    input logic idle,
    input logic rsp_valid,
    input logic pt_rd_valid
);

    // Set once the first request after reset has been presented
    logic req_seen;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_seen <= 1'b0;
        end
        else if (req_valid)
        begin
            req_seen <= 1'b1;
        end
    end

    // A response belongs to a request in flight so idle is low
    rsp_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !(rsp_valid && idle))
        else $error("rsp_valid high while idle is high");

    // Reads are single-cycle strobes
    rd_single_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        pt_rd_valid |=> !pt_rd_valid)
        else $error("pt_rd_valid high in two consecutive cycles");

    no_early_rsp: assert property (@(posedge clk) disable iff (!reset_n)
        !req_seen |-> !rsp_valid)
        else $error("rsp_valid before any request");

endmodule

bind vtp_top vtp_props props (
    .clk         (clk),
    .reset_n     (reset_n),
    .req_valid   (req_valid),
    .idle        (idle),
    .rsp_valid   (rsp_valid),
    .pt_rd_valid (pt_rd_valid)
);

//--- test/vtp_tb.sv
module vtp_tb
    import vtp_pkg::*;
();

    // ======================================================================
    // DUT ports
    // ======================================================================

    logic     clk = 1'b0;
    logic     reset_n;
    logic     req_valid;
    line_va_t req_addr;
    logic     req_is_virtual;
    logic     cfg_valid;
    line_pa_t cfg_base;
    logic     pt_rsp_valid;
    pt_line_t pt_rsp_data;
    logic     idle;
    logic     rsp_valid;
    line_pa_t rsp_addr;
    logic     rsp_error;
    logic     pt_rd_valid;
    line_pa_t pt_rd_addr;

    // Page table image indexed by line number relative to the current base
    pt_line_t pt_mem [256];
    logic     pt_loaded [256];
    line_pa_t tb_base;
    // Every page-table read address in issue order
    line_pa_t rd_log [$];
    int       mem_errors = 0;

    // Memory latency source
    logic [31:0] lfsr_state = 32'h23e2_ac5e;
    logic [2:0]  rsp_delay;
    line_pa_t    rd_offset;
    pt_idx_t     rd_idx;

    // Scoreboard
    int   check_errors = 0;
    int   tests_run = 0;
    int   tests_passed = 0;
    logic aborted = 1'b0;

    vtp_top dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_is_virtual (req_is_virtual),
        .idle           (idle),
        .rsp_valid      (rsp_valid),
        .rsp_addr       (rsp_addr),
        .rsp_error      (rsp_error),
        .cfg_valid      (cfg_valid),
        .cfg_base       (cfg_base),
        .pt_rd_valid    (pt_rd_valid),
        .pt_rd_addr     (pt_rd_addr),
        .pt_rsp_valid   (pt_rsp_valid),
        .pt_rsp_data    (pt_rsp_data)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 and the new bit shifted in at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ======================================================================
    // Page table memory model
    // ======================================================================

    // Each read is answered with one strobe after 1 to 8 cycles
    always
    begin
        @(negedge clk);
        if (reset_n && pt_rd_valid)
        begin
            rd_log.push_back(pt_rd_addr);
            rd_offset = pt_rd_addr - tb_base;
            rd_idx    = rd_offset[PT_IDX_BITS-1:0];
            if ((rd_offset[LINE_PA_BITS-1:PT_IDX_BITS] != '0) || !pt_loaded[rd_idx])
            begin
                $display("page-table read at %h falls outside the loaded lines", pt_rd_addr);
                mem_errors++;
            end
            // Three LFSR steps give the three delay bits
            for (int i = 0; i < 3; i++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                rsp_delay  = {rsp_delay[1:0], lfsr_state[0]};
            end
            repeat (int'(rsp_delay) + 1) @(posedge clk);
            pt_rsp_valid <= 1'b1;
            pt_rsp_data  <= pt_mem[rd_idx];
            @(posedge clk);
            pt_rsp_valid <= 1'b0;
        end
    end

    // ======================================================================
    // Helper tasks
    // ======================================================================

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
            check_errors++;
        end
    endtask

    // Comment lines run to the end of the line
    task automatic skip_comment(input int fd);
        int ch;
        ch = $fgetc(fd);
        while ((ch != 10) && (ch != -1))
        begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic wait_for_idle(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && (cycles < 100))
        begin
            @(negedge clk);
            cycles++;
            ok = (idle === 1'b1);
        end
    endtask

    task automatic load_base(input line_pa_t base);
        logic ok;
        wait_for_idle(ok);
        if (!ok)
        begin
            $display("idle never rose before the base load");
            aborted = 1'b1;
            return;
        end
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_base  <= base;
        tb_base = base;
        @(posedge clk);
        cfg_valid <= 1'b0;
        $display("base set to %h", base);
    endtask

    task automatic run_request(input line_va_t addr, input logic is_virtual,
                               input line_pa_t exp_addr, input logic exp_err,
                               input int exp_reads);
        logic     ok;
        int       lat;
        int       start_reads;
        int       errs_before;
        line_pa_t got_addr;
        logic     got_err;
        vpage_t   vpage;
        pt_idx_t  chain_idx;
        errs_before = check_errors;
        tests_run++;
        wait_for_idle(ok);
        if (!ok)
        begin
            $display("test %0d: idle never rose before the request", tests_run);
            aborted = 1'b1;
            return;
        end
        start_reads = rd_log.size();
        @(posedge clk);
        req_valid      <= 1'b1;
        req_addr       <= addr;
        req_is_virtual <= is_virtual;
        @(posedge clk);
        req_valid <= 1'b0;
        // Latency counts cycles after the one in which req_valid was high
        lat = 0;
        ok  = 1'b0;
        while (!ok && (lat < 200))
        begin
            @(negedge clk);
            lat++;
            ok = (rsp_valid === 1'b1);
            // The accepted request takes the path out of idle right away
            if (lat == 1)
            begin
                compare("idle", 32'(idle), 32'(0));
            end
        end
        if (!ok)
        begin
            $display("test %0d: no response to address %h within 200 cycles", tests_run, addr);
            aborted = 1'b1;
            return;
        end
        got_addr = rsp_addr;
        got_err  = rsp_error;
        compare("rsp_error", 32'(got_err), 32'(exp_err));
        if (!exp_err)
        begin
            compare("rsp_addr", 32'(got_addr), 32'(exp_addr));
        end
        compare("pt_rd_valid count", rd_log.size() - start_reads, exp_reads);
        // The walk starts at the hash line and follows each next-line pointer
        vpage     = addr[LINE_VA_BITS-1:PAGE_OFFSET_BITS];
        chain_idx = pt_idx_t'(vpage[PT_HASH_BITS-1:0]);
        for (int k = start_reads; k < rd_log.size(); k++)
        begin
            compare("pt_rd_addr", 32'(rd_log[k]), 32'(tb_base + line_pa_t'(chain_idx)));
            chain_idx = pt_mem[chain_idx][PT_LINE_BITS-1 -: PT_IDX_BITS];
        end
        if (!is_virtual)
        begin
            compare("rsp_valid latency", lat, 1);
        end
        else if (exp_reads == 0)
        begin
            compare("rsp_valid latency", lat, 3);
        end
        // Idle comes back in the cycle after the response
        @(negedge clk);
        compare("idle", 32'(idle), 32'(1));
        if (check_errors == errs_before)
        begin
            tests_passed++;
            $display("test %0d: address %h passed after %0d cycles", tests_run, addr, lat);
        end
        else
        begin
            $display("test %0d: address %h failed", tests_run, addr);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial
    begin
        int         fd;
        int         code;
        logic [7:0] kind;
        line_pa_t   base_val;
        pt_idx_t    l_idx;
        pt_line_t   l_data;
        line_va_t   r_addr;
        line_pa_t   r_exp;
        int         r_virt;
        int         r_err;
        int         r_reads;

        reset_n        = 1'b0;
        req_valid      = 1'b0;
        req_addr       = '0;
        req_is_virtual = 1'b0;
        cfg_valid      = 1'b0;
        cfg_base       = '0;
        pt_rsp_valid   = 1'b0;
        pt_rsp_data    = '0;
        tb_base        = '0;
        for (int i = 0; i < 256; i++)
        begin
            pt_mem[i]    = '0;
            pt_loaded[i] = 1'b0;
        end

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        fd = $fopen("test/vtp_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/vtp_cases.txt");
            aborted = 1'b1;
        end
        else
        begin
            // One record per line with its kind in the first character
            while (!aborted)
            begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1)
                begin
                    break;
                end
                case (kind)
                    "#":
                    begin
                        skip_comment(fd);
                    end
                    "B":
                    begin
                        code = $fscanf(fd, "%h", base_val);
                        load_base(base_val);
                    end
                    "L":
                    begin
                        code = $fscanf(fd, "%h %h", l_idx, l_data);
                        pt_mem[l_idx]    = l_data;
                        pt_loaded[l_idx] = 1'b1;
                    end
                    "R":
                    begin
                        code = $fscanf(fd, "%h %d %h %d %d", r_addr, r_virt, r_exp, r_err,
                                       r_reads);
                        if (code != 5)
                        begin
                            $display("malformed request record in the cases file");
                            aborted = 1'b1;
                        end
                        else
                        begin
                            run_request(r_addr, r_virt != 0, r_exp, r_err != 0, r_reads);
                        end
                    end
                    default:
                    begin
                        $display("unknown record kind in the cases file");
                        aborted = 1'b1;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("summary: %0d tests, %0d passed, %0d check errors, %0d memory errors",
                 tests_run, tests_passed, check_errors, mem_errors);
        if (!aborted && (tests_run > 0) && (tests_passed == tests_run) && (mem_errors == 0))
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/vtp_cases.txt
# B base_line_addr | L line_index line_data_128bit
# R vaddr virtual expected_paddr expected_error expected_pt_reads
B 1000
L 05 000000000000000000000049c700d0ab
L 09 40001505001104000d03000902000501
L 40 0000000000000000000000000000aef0
L 0c 0000290a002509002108001d07001906
R abcde 0 bcde 0 0
R 1214a 1 71ca 0 1
R 12173 1 71f3 0 0
R 2b241 1 bc01 0 2
R 3c142 1 0000 1 1
R 5533f 1 0000 1 1
R 77250 1 0000 1 2
R 2b27e 1 bc3e 0 0
B 2000
R 34147 1 2ac7 0 1
R 03260 1 40e0 0 1
R 0f00d 0 f00d 0 0

//--- sources.f
hdl/vtp_pkg.sv
hdl/vtp_pte_scan.sv
hdl/vtp_tlb.sv
hdl/vtp_walker.sv
hdl/vtp_request_path.sv
hdl/vtp_top.sv
test/vtp_props.sv
test/vtp_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module vtp_tb -o vtp_sim \
    || { echo "run_sim: build failed"; exit 1; }

./obj_dir/vtp_sim | tee /dev/stderr | grep -q "^Test completed successfully$" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
